/* verilog/dm9000a_reg_pkg.sv */
package dm9000a_reg_pkg;

   //////////////////////////////////////////////////
   // Bus pin levels and register indices
   //////////////////////////////////////////////////

   // Level of the CMD pin for each cycle type.
   localparam logic CMD_INDEX = 1'b0;
   localparam logic CMD_DATA  = 1'b1;

   localparam logic [7:0] NCR    = 8'h00;
   localparam logic [7:0] NSR    = 8'h01;
   localparam logic [7:0] RXCR   = 8'h05;
   localparam logic [7:0] PAR_0  = 8'h10;
   localparam logic [7:0] MAR_0  = 8'h16;
   localparam logic [7:0] GPR    = 8'h1f;
   localparam logic [7:0] MRCMDX = 8'hf0;
   localparam logic [7:0] MRCMD  = 8'hf2;
   localparam logic [7:0] ISR    = 8'hfe;
   localparam logic [7:0] IMR    = 8'hff;

   //////////////////////////////////////////////////
   // Bit masks
   //////////////////////////////////////////////////

   localparam logic [7:0] NCR_RST     = 8'h01;
   localparam logic [7:0] NSR_LINK    = 8'h40;
   // Wake, TX2 end and TX1 end are write-one-to-clear.
   localparam logic [7:0] NSR_CLEAR   = 8'h2c;
   localparam logic [7:0] ISR_PR      = 8'h01;
   localparam logic [7:0] ISR_LNKCHG  = 8'h20;
   localparam logic [7:0] ISR_ALL     = 8'h3f;
   localparam logic [7:0] IMR_PAR     = 8'h80;
   // Pointer auto-wrap, link change and packet received.
   localparam logic [7:0] IMR_ENABLE  = 8'ha1;
   // Promiscuous mode plus RX enable.
   localparam logic [7:0] RXCR_ENABLE = 8'h03;
   // Every RX status error flag except the multicast bit.
   localparam logic [7:0] RXSR_BAD    = 8'hbf;

   localparam logic [47:0] MAC_ADDRESS    = 48'h010203040506;
   localparam logic [63:0] MULTICAST_HASH = 64'h0;

   localparam logic [7:0] RESET_SPIN = 8'd12;
   localparam logic [7:0] PHY_SPIN   = 8'd24;
   localparam int         INIT_STEPS = 20;

endpackage

/* verilog/enet_ctrl_pkg.sv */
package enet_ctrl_pkg;

   typedef logic [15:0] enet_word_t;
   typedef logic [7:0]  reg_index_t;
   typedef logic [7:0]  spin_count_t;
   typedef logic [2:0]  credit_count_t;

   // Depth of the consumer's word buffer.
   localparam credit_count_t RX_CREDITS = 3'd4;

   typedef enum logic [1:0] {
      REG_RD,
      REG_WR,
      STREAM_SETUP,
      STREAM_RD
   } bus_op_e;

   typedef struct packed {
      logic       valid;
      bus_op_e    op;
      reg_index_t index;
      enet_word_t data;
   } bus_req_t;

   typedef struct packed {
      logic       valid;
      logic       last;
      enet_word_t data;
   } rx_word_t;

   //////////////////////////////////////////////////
   // FSM states
   //////////////////////////////////////////////////

   typedef enum logic [3:0] {
      CMD_SCRIPT, CMD_SPIN, CMD_IDLE, CMD_MASK, CMD_ISR_READ, CMD_ISR_CLEAR,
      CMD_DISPATCH, CMD_PREFETCH, CMD_RX_START, CMD_RX_WAIT, CMD_LINK, CMD_UNMASK
   } cmd_state_e;

   typedef enum logic [2:0] {
      BUS_IDLE, BUS_INDEX, BUS_TURN, BUS_WRITE, BUS_READ, BUS_FINISH
   } bus_state_e;

   typedef enum logic [2:0] {
      RX_IDLE, RX_SETUP, RX_STATUS, RX_LENGTH, RX_DATA
   } rx_state_e;

endpackage

/* verilog/init_script_rom.sv */
`timescale 1ns/10ps

module init_script_rom
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic [4:0]  step,
   output reg_index_t  index,
   output enet_word_t  data,
   output spin_count_t spin
);

   logic [63:0] hash;
   logic [2:0]  mac_pos;
   logic [2:0]  mar_pos;

   // Top hash bit set so broadcast frames get through.
   assign hash    = {1'b1, MULTICAST_HASH[62:0]};
   assign mac_pos = 3'(step - 5'd4);
   assign mar_pos = 3'(step - 5'd10);

   always_comb begin
      index = NCR;
      data  = '0;
      spin  = '0;
      case (step) inside
         5'd0: begin
            index = NCR;
            data  = {8'h00, NCR_RST};
            spin  = RESET_SPIN;
         end
         // Writing zero to GPR powers up the PHY.
         5'd1: begin
            index = GPR;
            spin  = PHY_SPIN;
         end
         5'd2: begin
            index = NSR;
            data  = {8'h00, NSR_CLEAR};
         end
         5'd3: begin
            index = ISR;
            data  = {8'h00, ISR_ALL};
         end
         [5'd4:5'd9]: begin
            index = PAR_0 + reg_index_t'(mac_pos);
            data  = {8'h00, MAC_ADDRESS[8*mac_pos +: 8]};
         end
         [5'd10:5'd17]: begin
            index = MAR_0 + reg_index_t'(mar_pos);
            data  = {8'h00, hash[8*mar_pos +: 8]};
         end
         5'd18: begin
            index = RXCR;
            data  = {8'h00, RXCR_ENABLE};
         end
         5'd19: begin
            index = IMR;
            data  = {8'h00, IMR_ENABLE};
         end
         default: ;
      endcase
   end

endmodule

/* verilog/enet_bus_engine.sv */
`timescale 1ns/10ps

module enet_bus_engine
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic       clk_enet,
   input  logic       reset,
   input  bus_req_t   req,
   input  enet_word_t enet_data_in,
   output logic       bus_done,
   output enet_word_t bus_rd_data,
   output logic       enet_cmd,
   output logic       enet_wr_n,
   output logic       enet_rd_n,
   output enet_word_t enet_data_out,
   output logic       enet_data_oe
);

   bus_state_e state;
   bus_op_e    cur_op;
   enet_word_t cur_data;

   // The chip only sees our data while the write strobe is low.
   assign enet_data_oe = ~enet_wr_n;

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state     <= BUS_IDLE;
         bus_done  <= 1'b0;
         enet_cmd  <= CMD_DATA;
         enet_wr_n <= 1'b1;
         enet_rd_n <= 1'b1;
      end else begin
         case (state)
            BUS_IDLE: begin
               if (req.valid) begin
                  cur_op   <= req.op;
                  cur_data <= req.data;
                  // Stream reads keep the index from the last setup.
                  if (req.op == STREAM_RD) begin
                     state     <= BUS_READ;
                     enet_cmd  <= CMD_DATA;
                     enet_rd_n <= 1'b0;
                  end else begin
                     state         <= BUS_INDEX;
                     enet_cmd      <= CMD_INDEX;
                     enet_wr_n     <= 1'b0;
                     enet_data_out <= {8'h00, req.index};
                  end
               end
            end
            // Both strobes go high for one cycle after the index.
            BUS_INDEX: begin
               state     <= BUS_TURN;
               enet_cmd  <= CMD_DATA;
               enet_wr_n <= 1'b1;
               bus_done  <= (cur_op == STREAM_SETUP);
            end
            BUS_TURN: begin
               if (cur_op == STREAM_SETUP) begin
                  state    <= BUS_IDLE;
                  bus_done <= 1'b0;
               end else if (cur_op == REG_WR) begin
                  state         <= BUS_WRITE;
                  enet_wr_n     <= 1'b0;
                  enet_data_out <= cur_data;
                  bus_done      <= 1'b1;
               end else begin
                  state     <= BUS_READ;
                  enet_rd_n <= 1'b0;
               end
            end
            BUS_WRITE: begin
               state     <= BUS_IDLE;
               enet_wr_n <= 1'b1;
               bus_done  <= 1'b0;
            end
            // Sample at the end of the read strobe cycle.
            BUS_READ: begin
               state       <= BUS_FINISH;
               enet_rd_n   <= 1'b1;
               bus_rd_data <= enet_data_in;
               bus_done    <= 1'b1;
            end
            BUS_FINISH: begin
               state    <= BUS_IDLE;
               bus_done <= 1'b0;
            end
            default: state <= BUS_IDLE;
         endcase
      end
   end

endmodule

/* verilog/rx_packet_reader.sv */
`timescale 1ns/10ps

module rx_packet_reader
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic       clk_enet,
   input  logic       reset,
   input  logic       rx_start,
   input  logic       bus_done,
   input  enet_word_t bus_rd_data,
   input  logic       rx_credit,
   output bus_req_t   rx_req,
   output logic       rx_busy,
   output rx_word_t   rx_word
);

   rx_state_e     state;
   credit_count_t credits;
   enet_word_t    words_left;
   logic          bad;
   logic          rd_done;
   logic          send;
   logic          issue_ok;

   assign rd_done = rx_req.valid && bus_done;
   assign send    = (state == RX_DATA) && rd_done && !bad;
   // Bad packets are drained without spending credits.
   assign issue_ok = (state != RX_IDLE) &&
                     ((state != RX_DATA) || (words_left != '0 && (bad || credits != '0)));

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         credits <= RX_CREDITS;
      end else begin
         credits <= credits + credit_count_t'(rx_credit) - credit_count_t'(send);
      end
   end

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state         <= RX_IDLE;
         rx_busy       <= 1'b0;
         rx_req.valid  <= 1'b0;
         rx_word.valid <= 1'b0;
      end else begin
         rx_word.valid <= 1'b0;
         if (rd_done) begin
            rx_req.valid <= 1'b0;
         end else if (!rx_req.valid && issue_ok) begin
            rx_req.valid <= 1'b1;
            rx_req.index <= MRCMD;
            rx_req.data  <= '0;
            if (state == RX_SETUP) begin
               rx_req.op <= STREAM_SETUP;
            end else begin
               rx_req.op <= STREAM_RD;
            end
         end
         case (state)
            RX_IDLE: begin
               if (rx_start) begin
                  state   <= RX_SETUP;
                  rx_busy <= 1'b1;
               end
            end
            RX_SETUP: if (rd_done) state <= RX_STATUS;
            // RX status sits in the high byte of the first word.
            RX_STATUS: begin
               if (rd_done) begin
                  bad   <= |(bus_rd_data[15:8] & RXSR_BAD);
                  state <= RX_LENGTH;
               end
            end
            RX_LENGTH: begin
               if (rd_done) begin
                  words_left <= {1'b0, bus_rd_data[15:1]} + {15'd0, bus_rd_data[0]};
                  state      <= RX_DATA;
               end
            end
            RX_DATA: begin
               if (rd_done) begin
                  words_left <= words_left - 16'd1;
                  rx_word    <= '{valid: !bad, last: (words_left == 16'd1), data: bus_rd_data};
               end else if (!rx_req.valid && words_left == '0) begin
                  state   <= RX_IDLE;
                  rx_busy <= 1'b0;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

/* verilog/enet_cmd_sequencer.sv */
`timescale 1ns/10ps

module enet_cmd_sequencer
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic        clk_enet,
   input  logic        reset,
   input  logic        enet_int,
   input  logic        bus_done,
   input  enet_word_t  bus_rd_data,
   input  logic        rx_busy,
   input  reg_index_t  rom_index,
   input  enet_word_t  rom_data,
   input  spin_count_t rom_spin,
   input  bus_req_t    rx_req,
   output logic [4:0]  step,
   output bus_req_t    req,
   output logic        rx_start,
   output logic        link_status
);

   cmd_state_e  state;
   bus_req_t    seq_req;
   spin_count_t spin_left;
   logic [7:0]  isr_flags;
   logic        op_active;
   bus_op_e     op;
   reg_index_t  op_index;
   enet_word_t  op_data;
   logic        op_done;
   logic        last_step;

   // The packet reader owns the bus for the whole packet.
   assign req       = rx_busy ? rx_req : seq_req;
   assign op_done   = seq_req.valid && bus_done;
   assign last_step = (step == 5'(INIT_STEPS - 1));

   //////////////////////////////////////////////////
   // Bus operation of each state
   //////////////////////////////////////////////////

   always_comb begin
      op_active = 1'b1;
      op        = REG_WR;
      op_index  = rom_index;
      op_data   = rom_data;
      case (state)
         CMD_SCRIPT: ;
         CMD_MASK: begin
            op_index = IMR;
            op_data  = {8'h00, IMR_PAR};
         end
         CMD_ISR_READ: begin
            op       = REG_RD;
            op_index = ISR;
         end
         CMD_ISR_CLEAR: begin
            op_index = ISR;
            op_data  = {8'h00, ISR_ALL};
         end
         CMD_PREFETCH: begin
            op       = REG_RD;
            op_index = MRCMDX;
         end
         CMD_LINK: begin
            op       = REG_RD;
            op_index = NSR;
         end
         CMD_UNMASK: begin
            op_index = IMR;
            op_data  = {8'h00, IMR_ENABLE};
         end
         default: op_active = 1'b0;
      endcase
   end

   //////////////////////////////////////////////////
   // Control FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk_enet) begin
      if (reset) begin
         state         <= CMD_SCRIPT;
         step          <= '0;
         spin_left     <= '0;
         isr_flags     <= '0;
         seq_req.valid <= 1'b0;
         rx_start      <= 1'b0;
         link_status   <= 1'b0;
      end else begin
         rx_start <= 1'b0;
         if (op_done) begin
            seq_req.valid <= 1'b0;
         end else if (op_active && !seq_req.valid) begin
            seq_req <= '{valid: 1'b1, op: op, index: op_index, data: op_data};
         end
         case (state)
            CMD_SCRIPT: begin
               if (op_done) begin
                  spin_left <= rom_spin;
                  state     <= CMD_SPIN;
               end
            end
            // A zero spin just moves on to the next step.
            CMD_SPIN: begin
               if (spin_left > 8'd1) begin
                  spin_left <= spin_left - 8'd1;
               end else if (last_step) begin
                  state <= CMD_IDLE;
               end else begin
                  step  <= step + 5'd1;
                  state <= CMD_SCRIPT;
               end
            end
            CMD_IDLE: if (enet_int) state <= CMD_MASK;
            CMD_MASK: if (op_done) state <= CMD_ISR_READ;
            CMD_ISR_READ: begin
               if (op_done) begin
                  isr_flags <= bus_rd_data[7:0];
                  state     <= CMD_ISR_CLEAR;
               end
            end
            CMD_ISR_CLEAR: if (op_done) state <= CMD_DISPATCH;
            CMD_DISPATCH: begin
               if (|(isr_flags & ISR_PR)) begin
                  state <= CMD_PREFETCH;
               end else if (|(isr_flags & ISR_LNKCHG)) begin
                  state <= CMD_LINK;
               end else begin
                  state <= CMD_UNMASK;
               end
            end
            // Ready byte of 1 means another packet is waiting.
            CMD_PREFETCH: begin
               if (op_done) begin
                  if (bus_rd_data[15:8] == 8'h01) begin
                     rx_start <= 1'b1;
                     state    <= CMD_RX_START;
                  end else begin
                     isr_flags <= isr_flags & ~ISR_PR;
                     state     <= CMD_DISPATCH;
                  end
               end
            end
            CMD_RX_START: state <= CMD_RX_WAIT;
            CMD_RX_WAIT: if (!rx_busy) state <= CMD_PREFETCH;
            CMD_LINK: begin
               if (op_done) begin
                  link_status <= |(bus_rd_data[7:0] & NSR_LINK);
                  isr_flags   <= isr_flags & ~ISR_LNKCHG;
                  state       <= CMD_DISPATCH;
               end
            end
            CMD_UNMASK: if (op_done) state <= CMD_IDLE;
            default: state <= CMD_IDLE;
         endcase
      end
   end

endmodule

/* verilog/dm9000a_controller.sv */
`timescale 1ns/10ps

module dm9000a_controller
   import enet_ctrl_pkg::*;
(
   input  logic       clk_enet,
   input  logic       reset,
   input  logic       enet_int,
   input  enet_word_t enet_data_in,
   input  logic       rx_credit,
   output logic       enet_cmd,
   output logic       enet_wr_n,
   output logic       enet_rd_n,
   output enet_word_t enet_data_out,
   output logic       enet_data_oe,
   output rx_word_t   rx_word,
   output logic       link_status
);

   logic [4:0]  step;
   reg_index_t  rom_index;
   enet_word_t  rom_data;
   spin_count_t rom_spin;
   bus_req_t    bus_req;
   bus_req_t    rx_req;
   logic        bus_done;
   enet_word_t  bus_rd_data;
   logic        rx_start;
   logic        rx_busy;

   enet_cmd_sequencer u_sequencer (
      .clk_enet    (clk_enet),
      .reset       (reset),
      .enet_int    (enet_int),
      .bus_done    (bus_done),
      .bus_rd_data (bus_rd_data),
      .rx_busy     (rx_busy),
      .rom_index   (rom_index),
      .rom_data    (rom_data),
      .rom_spin    (rom_spin),
      .rx_req      (rx_req),
      .step        (step),
      .req         (bus_req),
      .rx_start    (rx_start),
      .link_status (link_status)
   );

   init_script_rom u_script_rom (
      .step  (step),
      .index (rom_index),
      .data  (rom_data),
      .spin  (rom_spin)
   );

   enet_bus_engine u_bus_engine (
      .clk_enet      (clk_enet),
      .reset         (reset),
      .req           (bus_req),
      .enet_data_in  (enet_data_in),
      .bus_done      (bus_done),
      .bus_rd_data   (bus_rd_data),
      .enet_cmd      (enet_cmd),
      .enet_wr_n     (enet_wr_n),
      .enet_rd_n     (enet_rd_n),
      .enet_data_out (enet_data_out),
      .enet_data_oe  (enet_data_oe)
   );

   rx_packet_reader u_rx_reader (
      .clk_enet    (clk_enet),
      .reset       (reset),
      .rx_start    (rx_start),
      .bus_done    (bus_done),
      .bus_rd_data (bus_rd_data),
      .rx_credit   (rx_credit),
      .rx_req      (rx_req),
      .rx_busy     (rx_busy),
      .rx_word     (rx_word)
   );

endmodule

/* tb/rx_checker.sv */
`timescale 1ns/10ps

module rx_checker
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
(
   input  logic       clk_enet,
   input  logic       reset,
   input  logic       enet_cmd,
   input  logic       enet_wr_n,
   input  logic       enet_rd_n,
   input  enet_word_t enet_data_out,
   input  logic       enet_data_oe,
   input  rx_word_t   rx_word,
   input  logic       rx_credit,
   input  logic       link_status,
   input  logic       exp_link,
   input  logic       pkt_push,
   input  logic [7:0] pkt_status,
   input  logic [7:0] pkt_len,
   input  logic [7:0] pkt_seed,
   output int         writes_seen,
   output int         irq_done,
   output int         exp_pending,
   output int         mismatches
);

   logic [7:0]  cur_index;
   logic        in_irq = 1'b0;
   logic [23:0] exp_pair;
   logic [16:0] exp_q[$];
   logic [16:0] exp_head;
   int          n_writes = 0;
   int          n_irq = 0;
   int          n_err = 0;
   int          sent = 0;
   int          returned = 0;
   int          n_words;

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // Register index in the top byte, written word below it.
   function automatic logic [23:0] script_pair(input int n);
      logic [63:0] hash;
      hash = MULTICAST_HASH | 64'h8000_0000_0000_0000;
      case (n)
         0:  return {NCR, 8'h00, NCR_RST};
         1:  return {GPR, 16'h0000};
         2:  return {NSR, 8'h00, NSR_CLEAR};
         3:  return {ISR, 8'h00, ISR_ALL};
         18: return {RXCR, 8'h00, RXCR_ENABLE};
         19: return {IMR, 8'h00, IMR_ENABLE};
         default: begin
            if (n < 10) begin
               return {PAR_0 + 8'(n - 4), 8'h00, 8'(MAC_ADDRESS >> (8 * (n - 4)))};
            end
            return {MAR_0 + 8'(n - 10), 8'h00, 8'(hash >> (8 * (n - 10)))};
         end
      endcase
   endfunction

   function automatic logic [7:0] payload_byte(input logic [7:0] seed, input int k);
      return 8'(int'(seed) * 29 + k * 53 + (k >> 2));
   endfunction

   // Little endian packing, odd tail padded with zero.
   function automatic enet_word_t expected_word(input logic [7:0] seed, input int len,
                                                input int i);
      logic [7:0] hi;
      hi = (2 * i + 1 < len) ? payload_byte(seed, 2 * i + 1) : 8'h00;
      return {hi, payload_byte(seed, 2 * i)};
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      n_err++;
   endtask

   //////////////////////////////////////////////////
   // Port monitor
   //////////////////////////////////////////////////

   always @(posedge clk_enet) begin
      if (!reset) begin
         if (enet_data_oe !== !enet_wr_n) begin
            report_mismatch("enet_data_oe", 32'(!enet_wr_n), 32'(enet_data_oe));
         end
         // Reads are data cycles with the write strobe high.
         if (!enet_rd_n && (!enet_wr_n || !enet_cmd)) begin
            report_mismatch("enet_rd_n", 32'h1, 32'h0);
         end
         if (!enet_wr_n && !enet_cmd) begin
            cur_index = enet_data_out[7:0];
         end else if (!enet_wr_n) begin
            if (n_writes < INIT_STEPS) begin
               exp_pair = script_pair(n_writes);
               if ({cur_index, enet_data_out} !== exp_pair) begin
                  report_mismatch("enet_data_out", 32'(exp_pair), 32'({cur_index, enet_data_out}));
               end
            end else if (cur_index == IMR) begin
               if (enet_data_out == {8'h00, IMR_PAR}) begin
                  in_irq = 1'b1;
               end else if (in_irq && enet_data_out == {8'h00, IMR_ENABLE}) begin
                  in_irq = 1'b0;
                  n_irq++;
                  if (link_status !== exp_link) begin
                     report_mismatch("link_status", 32'(exp_link), 32'(link_status));
                  end
               end else begin
                  report_mismatch("IMR", 32'(IMR_ENABLE), 32'(enet_data_out));
               end
            end
            n_writes++;
         end

         // Only good packets are expected on the stream.
         if (pkt_push && ((pkt_status & RXSR_BAD) == 8'h00)) begin
            n_words = (int'(pkt_len) + 1) / 2;
            for (int i = 0; i < n_words; i++) begin
               exp_q.push_back({i == n_words - 1, expected_word(pkt_seed, int'(pkt_len), i)});
            end
         end

         if (rx_word.valid) begin
            sent++;
            if (exp_q.size() == 0) begin
               report_mismatch("rx_word.valid", 32'h0, 32'h1);
            end else begin
               exp_head = exp_q.pop_front();
               if (rx_word.data !== exp_head[15:0]) begin
                  report_mismatch("rx_word.data", 32'(exp_head[15:0]), 32'(rx_word.data));
               end
               if (rx_word.last !== exp_head[16]) begin
                  report_mismatch("rx_word.last", 32'(exp_head[16]), 32'(rx_word.last));
               end
            end
         end
         if (rx_credit) begin
            returned++;
         end
         if (sent - returned > int'(RX_CREDITS)) begin
            report_mismatch("credits_in_use", 32'(RX_CREDITS), 32'(sent - returned));
         end
      end
      writes_seen <= n_writes;
      irq_done    <= n_irq;
      exp_pending <= exp_q.size();
      mismatches  <= n_err;
   end

endmodule

/* tb/tb_dm9000a.sv */
`timescale 1ns/10ps

module tb_dm9000a
   import dm9000a_reg_pkg::*;
   import enet_ctrl_pkg::*;
;

   logic       clk_enet;
   logic       reset;
   logic       enet_int = 1'b0;
   enet_word_t enet_data_in = '0;
   logic       rx_credit = 1'b0;
   logic       enet_cmd;
   logic       enet_wr_n;
   logic       enet_rd_n;
   enet_word_t enet_data_out;
   logic       enet_data_oe;
   rx_word_t   rx_word;
   logic       link_status;

   logic       pkt_push;
   logic [7:0] pkt_status;
   logic [7:0] pkt_len;
   logic [7:0] pkt_seed;
   logic       link_evt;
   logic       link_val;
   logic       hold;
   logic       exp_link;
   int         writes_seen;
   int         irq_done;
   int         exp_pending;
   int         mismatches;
   int         timeouts = 0;

   dm9000a_controller uut (
      .clk_enet      (clk_enet),
      .reset         (reset),
      .enet_int      (enet_int),
      .enet_data_in  (enet_data_in),
      .rx_credit     (rx_credit),
      .enet_cmd      (enet_cmd),
      .enet_wr_n     (enet_wr_n),
      .enet_rd_n     (enet_rd_n),
      .enet_data_out (enet_data_out),
      .enet_data_oe  (enet_data_oe),
      .rx_word       (rx_word),
      .link_status   (link_status)
   );

   rx_checker u_checker (
      .clk_enet      (clk_enet),
      .reset         (reset),
      .enet_cmd      (enet_cmd),
      .enet_wr_n     (enet_wr_n),
      .enet_rd_n     (enet_rd_n),
      .enet_data_out (enet_data_out),
      .enet_data_oe  (enet_data_oe),
      .rx_word       (rx_word),
      .rx_credit     (rx_credit),
      .link_status   (link_status),
      .exp_link      (exp_link),
      .pkt_push      (pkt_push),
      .pkt_status    (pkt_status),
      .pkt_len       (pkt_len),
      .pkt_seed      (pkt_seed),
      .writes_seen   (writes_seen),
      .irq_done      (irq_done),
      .exp_pending   (exp_pending),
      .mismatches    (mismatches)
   );

   initial begin
      clk_enet = 1'b0;
      forever #2 clk_enet = ~clk_enet;
   end

   //////////////////////////////////////////////////
   // DM9000A chip model
   //////////////////////////////////////////////////

   logic [7:0] regs [256];
   logic [7:0] isr;
   logic [7:0] imr;
   logic [7:0] nsr = 8'h00;
   logic [7:0] cur_index;
   logic [7:0] lo;
   logic [7:0] hi;
   enet_word_t stream[$];

   assign exp_link = |(nsr & NSR_LINK);

   always @(posedge clk_enet) begin
      if (reset) begin
         foreach (regs[i]) regs[i] = 8'h00;
         isr = 8'h00;
         imr = 8'h00;
         nsr <= 8'h00;
         cur_index = 8'h00;
         stream.delete();
         enet_int     <= 1'b0;
         enet_data_in <= '0;
      end else begin
         if (!enet_wr_n && !enet_cmd) begin
            cur_index = enet_data_out[7:0];
         end else if (!enet_wr_n) begin
            case (cur_index)
               ISR: isr = isr & ~enet_data_out[7:0];
               IMR: imr = enet_data_out[7:0];
               default: regs[cur_index] = enet_data_out[7:0];
            endcase
         end
         // Each MRCMD read moves the RX pointer by one word.
         if (!enet_rd_n && cur_index == MRCMD && stream.size() > 0) begin
            void'(stream.pop_front());
         end
         if (pkt_push) begin
            stream.push_back({pkt_status, 8'h01});
            stream.push_back({8'h00, pkt_len});
            for (int k = 0; k < int'(pkt_len); k += 2) begin
               lo = 8'(int'(pkt_seed) * 29 + k * 53 + (k >> 2));
               hi = 8'h00;
               if (k + 1 < int'(pkt_len)) begin
                  hi = 8'(int'(pkt_seed) * 29 + (k + 1) * 53 + ((k + 1) >> 2));
               end
               stream.push_back({hi, lo});
            end
            isr = isr | ISR_PR;
         end
         if (link_evt) begin
            nsr <= link_val ? NSR_LINK : 8'h00;
            isr = isr | ISR_LNKCHG;
         end
         enet_int <= |(isr & imr & (ISR_PR | ISR_LNKCHG));
         case (cur_index)
            ISR:     enet_data_in <= {8'h00, isr};
            NSR:     enet_data_in <= {8'h00, nsr};
            MRCMDX:  enet_data_in <= {(stream.size() > 0) ? 8'h01 : 8'h00, 8'h00};
            MRCMD:   enet_data_in <= (stream.size() > 0) ? stream[0] : 16'h0000;
            default: enet_data_in <= {8'h00, regs[cur_index]};
         endcase
      end
   end

   // Consumer returns one credit per word after a short random gap.
   int owed = 0;
   int gap = 0;

   always @(posedge clk_enet) begin
      rx_credit <= 1'b0;
      if (reset) begin
         owed = 0;
         gap  = 0;
      end else begin
         if (owed > 0 && !hold) begin
            if (gap == 0) begin
               rx_credit <= 1'b1;
               owed--;
               gap = int'($urandom % 4);
            end else begin
               gap--;
            end
         end
         if (rx_word.valid) owed++;
      end
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic push_packet(input logic [7:0] status, input logic [7:0] len);
      @(posedge clk_enet);
      pkt_push   <= 1'b1;
      pkt_status <= status;
      pkt_len    <= len;
      pkt_seed   <= 8'($urandom);
      @(posedge clk_enet);
      pkt_push <= 1'b0;
   endtask

   task automatic link_change(input logic up);
      @(posedge clk_enet);
      link_evt <= 1'b1;
      link_val <= up;
      @(posedge clk_enet);
      link_evt <= 1'b0;
   endtask

   task automatic wait_script_done();
      int n;
      n = 0;
      while (writes_seen < INIT_STEPS && n < 3000) begin
         @(posedge clk_enet);
         n++;
      end
      if (writes_seen < INIT_STEPS) begin
         $display("Timed out waiting for the initialization script.");
         timeouts++;
      end
   endtask

   task automatic wait_irqs(input int target);
      int n;
      n = 0;
      while (irq_done < target && n < 3000) begin
         @(posedge clk_enet);
         n++;
      end
      if (irq_done < target) begin
         $display("Timed out waiting for interrupt %0d to finish.", target);
         timeouts++;
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (exp_pending != 0 && n < 3000) begin
         @(posedge clk_enet);
         n++;
      end
      if (exp_pending != 0) begin
         $display("Timed out with %0d packet words still missing.", exp_pending);
         timeouts++;
      end
   endtask

   initial begin
      void'($urandom(87));
      reset      = 1'b1;
      pkt_push   = 1'b0;
      pkt_status = 8'h00;
      pkt_len    = 8'h00;
      pkt_seed   = 8'h00;
      link_evt   = 1'b0;
      link_val   = 1'b0;
      hold       = 1'b0;
      repeat (3) @(posedge clk_enet);
      reset <= 1'b0;

      wait_script_done();
      link_change(1'b1);
      wait_irqs(1);
      link_change(1'b0);
      wait_irqs(2);

      push_packet(8'h00, 8'(2 * ($urandom % 20) + 5));
      wait_irqs(3);
      wait_drained();

      // CRC error flag set on the first packet.
      push_packet(8'h02, 8'd9);
      push_packet(8'h00, 8'(2 * ($urandom % 20) + 5));
      wait_irqs(4);
      wait_drained();

      hold <= 1'b1;
      push_packet(8'h00, 8'd15);
      repeat (100) @(posedge clk_enet);
      hold <= 1'b0;
      wait_irqs(5);
      wait_drained();

      repeat (20) @(posedge clk_enet);
      $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* list.f */
verilog/dm9000a_reg_pkg.sv
verilog/enet_ctrl_pkg.sv
verilog/init_script_rom.sv
verilog/enet_bus_engine.sv
verilog/rx_packet_reader.sv
verilog/enet_cmd_sequencer.sv
verilog/dm9000a_controller.sv
tb/rx_checker.sv
tb/tb_dm9000a.sv

/* run.sh */
#!/bin/sh
# Build and run the DM9000A receive controller simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_dm9000a -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
   exit 0
fi
exit 1
